// ==== verilog/csr_isa_pkg.sv ====
`default_nettype none

package csr_isa_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [11:0] csr_addr_t;

    // Encoded as in mstatus.MPP
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01,
        PRIV_M = 2'b11
    } priv_mode_e;

    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_WRITE = 3'd1,
        CMD_SET   = 3'd2,
        CMD_CLEAR = 3'd3,
        CMD_ECALL = 3'd4,
        CMD_MRET  = 3'd5,
        CMD_SRET  = 3'd6
    } csr_cmd_e;

    // Supervisor trap setup and handling
    localparam csr_addr_t ADDR_SSTATUS  = 12'h100;
    localparam csr_addr_t ADDR_STVEC    = 12'h105;
    localparam csr_addr_t ADDR_SSCRATCH = 12'h140;
    localparam csr_addr_t ADDR_SEPC     = 12'h141;
    localparam csr_addr_t ADDR_SCAUSE   = 12'h142;
    localparam csr_addr_t ADDR_STVAL    = 12'h143;

    // Machine trap setup and handling
    localparam csr_addr_t ADDR_MSTATUS  = 12'h300;
    localparam csr_addr_t ADDR_MISA     = 12'h301;
    localparam csr_addr_t ADDR_MEDELEG  = 12'h302;
    localparam csr_addr_t ADDR_MTVEC    = 12'h305;
    localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t ADDR_MEPC     = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE   = 12'h342;
    localparam csr_addr_t ADDR_MTVAL    = 12'h343;

    localparam xlen_t CAUSE_ILLEGAL_INSTRUCTION = 32'd2;
    // ECALL from S and M follow at 9 and 11
    localparam xlen_t CAUSE_ECALL_U             = 32'd8;

    // RV32 with A, I, M, S and U
    localparam xlen_t MISA_VALUE = 32'h4014_1101;

    localparam int unsigned MSTATUS_SIE_BIT    = 1;
    localparam int unsigned MSTATUS_MIE_BIT    = 3;
    localparam int unsigned MSTATUS_SPIE_BIT   = 5;
    localparam int unsigned MSTATUS_MPIE_BIT   = 7;
    localparam int unsigned MSTATUS_SPP_BIT    = 8;
    localparam int unsigned MSTATUS_MPP_LO_BIT = 11;
    localparam int unsigned MSTATUS_MPP_HI_BIT = 12;
    localparam int unsigned MSTATUS_TSR_BIT    = 22;

    // Fields of mstatus visible through sstatus
    localparam xlen_t SSTATUS_MASK = 32'h0000_0122;

    // Direct mode only
    localparam xlen_t XTVEC_BASE_MASK = 32'hFFFF_FFFC;

endpackage

`default_nettype wire

// ==== verilog/csr_if_pkg.sv ====
`default_nettype none

package csr_if_pkg;

    typedef struct packed {
        csr_isa_pkg::csr_cmd_e  cmd;
        csr_isa_pkg::csr_addr_t addr;
        csr_isa_pkg::xlen_t     operand;
        csr_isa_pkg::xlen_t     pc;
        logic                   exc_valid;
        csr_isa_pkg::xlen_t     exc_cause;
    } csr_req_t;

    typedef struct packed {
        csr_isa_pkg::xlen_t rdata;
        // Destination register must not be written
        logic               no_wb;
        logic               redirect;
        csr_isa_pkg::xlen_t target;
    } csr_resp_t;

    // Trap entry or xRET already qualified by the request valid
    typedef struct packed {
        logic               take;
        logic               to_m;
        csr_isa_pkg::xlen_t cause;
        logic               is_mret;
        logic               is_sret;
        csr_isa_pkg::xlen_t pc;
    } trap_req_t;

endpackage

`default_nettype wire

// ==== verilog/csr_access_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_access_check (
    input  wire csr_if_pkg::csr_req_t   req_i,
    input  wire csr_isa_pkg::priv_mode_e mode_i,
    input  wire                         tsr_i,
    output logic                        illegal_o,
    output logic                        readonly_o
);

    logic is_write;
    logic no_priv;
    logic mret_bad;
    logic sret_bad;

    assign is_write = (req_i.cmd == csr_isa_pkg::CMD_WRITE) ||
                      (req_i.cmd == csr_isa_pkg::CMD_SET) ||
                      (req_i.cmd == csr_isa_pkg::CMD_CLEAR);

    // Address bits 9:8 hold the lowest mode allowed to access the CSR
    assign no_priv = is_write && (req_i.addr[9:8] > mode_i);

    assign mret_bad = (req_i.cmd == csr_isa_pkg::CMD_MRET) &&
                      (mode_i != csr_isa_pkg::PRIV_M);

    // SRET needs at least S and TSR traps it in S
    assign sret_bad = (req_i.cmd == csr_isa_pkg::CMD_SRET) &&
                      ((mode_i == csr_isa_pkg::PRIV_U) ||
                       ((mode_i == csr_isa_pkg::PRIV_S) && tsr_i));

    assign illegal_o = no_priv || mret_bad || sret_bad;

    // Top quarter of the address space is read-only
    assign readonly_o = req_i.addr[11:10] == 2'b11;

endmodule

`default_nettype wire

// ==== verilog/csr_trap_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_trap_ctrl (
    input  wire                          clk,
    input  wire                          arst_n_i,
    input  wire                          req_valid_i,
    input  wire csr_if_pkg::csr_req_t    req_i,
    input  wire                          illegal_i,
    input  wire csr_isa_pkg::priv_mode_e mode_i,
    input  wire csr_isa_pkg::xlen_t      medeleg_i,
    input  wire csr_isa_pkg::xlen_t      mtvec_i,
    input  wire csr_isa_pkg::xlen_t      stvec_i,
    input  wire csr_isa_pkg::xlen_t      mepc_i,
    input  wire csr_isa_pkg::xlen_t      sepc_i,
    input  wire csr_isa_pkg::xlen_t      rdata_i,
    output csr_if_pkg::trap_req_t        trap_o,
    output logic                         resp_valid_o,
    output csr_if_pkg::csr_resp_t        resp_o
);

    logic               is_ecall;
    logic               raise;
    csr_isa_pkg::xlen_t cause;
    logic               to_m;

    assign is_ecall = req_i.cmd == csr_isa_pkg::CMD_ECALL;
    assign raise    = req_i.exc_valid || is_ecall || illegal_i;

    // Upstream exception wins over ECALL and ECALL over illegal
    always_comb begin
        if (req_i.exc_valid) begin
            cause = req_i.exc_cause;
        end else if (is_ecall) begin
            cause = csr_isa_pkg::CAUSE_ECALL_U + {30'b0, mode_i};
        end else begin
            cause = csr_isa_pkg::CAUSE_ILLEGAL_INSTRUCTION;
        end
    end

    // M-mode never delegates downwards
    assign to_m = (mode_i == csr_isa_pkg::PRIV_M) || !medeleg_i[cause[4:0]];

    always_comb begin
        trap_o.take    = req_valid_i && raise;
        trap_o.to_m    = to_m;
        trap_o.cause   = cause;
        trap_o.is_mret = req_valid_i && !raise && (req_i.cmd == csr_isa_pkg::CMD_MRET);
        trap_o.is_sret = req_valid_i && !raise && (req_i.cmd == csr_isa_pkg::CMD_SRET);
        trap_o.pc      = req_i.pc;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= req_valid_i;
        end
    end

    // Response payload captured with each request
    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            if (trap_o.take) begin
                resp_o.rdata    <= '0;
                resp_o.no_wb    <= 1'b1;
                resp_o.redirect <= 1'b1;
                resp_o.target   <= to_m ? mtvec_i : stvec_i;
            end else if (trap_o.is_mret || trap_o.is_sret) begin
                resp_o.rdata    <= '0;
                resp_o.no_wb    <= 1'b1;
                resp_o.redirect <= 1'b1;
                resp_o.target   <= trap_o.is_mret ? mepc_i : sepc_i;
            end else begin
                resp_o.rdata    <= rdata_i;
                resp_o.no_wb    <= 1'b0;
                resp_o.redirect <= 1'b0;
                resp_o.target   <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/csr_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_regfile (
    input  wire                          clk,
    input  wire                          arst_n_i,
    input  wire                          req_valid_i,
    input  wire csr_if_pkg::csr_req_t    req_i,
    input  wire                          readonly_i,
    input  wire csr_if_pkg::trap_req_t   trap_i,
    output csr_isa_pkg::priv_mode_e      mode_o,
    output logic                         tsr_o,
    output csr_isa_pkg::xlen_t           medeleg_o,
    output csr_isa_pkg::xlen_t           mtvec_o,
    output csr_isa_pkg::xlen_t           stvec_o,
    output csr_isa_pkg::xlen_t           mepc_o,
    output csr_isa_pkg::xlen_t           sepc_o,
    output csr_isa_pkg::xlen_t           rdata_o
);

    csr_isa_pkg::priv_mode_e mode;

    // mstatus fields
    logic                    st_tsr;
    csr_isa_pkg::priv_mode_e st_mpp;
    logic                    st_spp;
    logic                    st_mpie;
    logic                    st_spie;
    logic                    st_mie;
    logic                    st_sie;

    csr_isa_pkg::xlen_t medeleg;
    csr_isa_pkg::xlen_t mtvec;
    csr_isa_pkg::xlen_t mscratch;
    csr_isa_pkg::xlen_t mepc;
    csr_isa_pkg::xlen_t mcause;
    csr_isa_pkg::xlen_t mtval;
    csr_isa_pkg::xlen_t stvec;
    csr_isa_pkg::xlen_t sscratch;
    csr_isa_pkg::xlen_t sepc;
    csr_isa_pkg::xlen_t scause;
    csr_isa_pkg::xlen_t stval;

    csr_isa_pkg::xlen_t mstatus;
    csr_isa_pkg::xlen_t wdata;
    logic               do_write;
    logic [1:0]         wr_mpp;

    always_comb begin
        mstatus = '0;
        mstatus[csr_isa_pkg::MSTATUS_TSR_BIT]  = st_tsr;
        mstatus[csr_isa_pkg::MSTATUS_MPP_HI_BIT:csr_isa_pkg::MSTATUS_MPP_LO_BIT] = st_mpp;
        mstatus[csr_isa_pkg::MSTATUS_SPP_BIT]  = st_spp;
        mstatus[csr_isa_pkg::MSTATUS_MPIE_BIT] = st_mpie;
        mstatus[csr_isa_pkg::MSTATUS_SPIE_BIT] = st_spie;
        mstatus[csr_isa_pkg::MSTATUS_MIE_BIT]  = st_mie;
        mstatus[csr_isa_pkg::MSTATUS_SIE_BIT]  = st_sie;
    end

    always_comb begin
        case (req_i.addr)
            csr_isa_pkg::ADDR_MSTATUS:  rdata_o = mstatus;
            csr_isa_pkg::ADDR_MISA:     rdata_o = csr_isa_pkg::MISA_VALUE;
            csr_isa_pkg::ADDR_MEDELEG:  rdata_o = medeleg;
            csr_isa_pkg::ADDR_MTVEC:    rdata_o = mtvec;
            csr_isa_pkg::ADDR_MSCRATCH: rdata_o = mscratch;
            csr_isa_pkg::ADDR_MEPC:     rdata_o = mepc;
            csr_isa_pkg::ADDR_MCAUSE:   rdata_o = mcause;
            csr_isa_pkg::ADDR_MTVAL:    rdata_o = mtval;
            csr_isa_pkg::ADDR_SSTATUS:  rdata_o = mstatus & csr_isa_pkg::SSTATUS_MASK;
            csr_isa_pkg::ADDR_STVEC:    rdata_o = stvec;
            csr_isa_pkg::ADDR_SSCRATCH: rdata_o = sscratch;
            csr_isa_pkg::ADDR_SEPC:     rdata_o = sepc;
            csr_isa_pkg::ADDR_SCAUSE:   rdata_o = scause;
            csr_isa_pkg::ADDR_STVAL:    rdata_o = stval;
            default:                    rdata_o = '0;
        endcase
    end

    always_comb begin
        case (req_i.cmd)
            csr_isa_pkg::CMD_WRITE: wdata = req_i.operand;
            csr_isa_pkg::CMD_SET:   wdata = rdata_o | req_i.operand;
            csr_isa_pkg::CMD_CLEAR: wdata = rdata_o & ~req_i.operand;
            default:                wdata = rdata_o;
        endcase
    end

    assign do_write = req_valid_i && !trap_i.take && !readonly_i &&
                      ((req_i.cmd == csr_isa_pkg::CMD_WRITE) ||
                       (req_i.cmd == csr_isa_pkg::CMD_SET) ||
                       (req_i.cmd == csr_isa_pkg::CMD_CLEAR));

    // MPP value 2 is reserved and falls back to U
    assign wr_mpp = wdata[csr_isa_pkg::MSTATUS_MPP_HI_BIT:csr_isa_pkg::MSTATUS_MPP_LO_BIT];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mode     <= csr_isa_pkg::PRIV_M;
            st_tsr   <= 1'b0;
            st_mpp   <= csr_isa_pkg::PRIV_M;
            st_spp   <= 1'b0;
            st_mpie  <= 1'b0;
            st_spie  <= 1'b0;
            st_mie   <= 1'b0;
            st_sie   <= 1'b0;
            medeleg  <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            stvec    <= '0;
            sscratch <= '0;
            sepc     <= '0;
            scause   <= '0;
            stval    <= '0;
        end else if (trap_i.take) begin
            if (trap_i.to_m) begin
                mode    <= csr_isa_pkg::PRIV_M;
                mcause  <= trap_i.cause;
                mepc    <= trap_i.pc;
                mtval   <= '0;
                st_mpie <= st_mie;
                st_mie  <= 1'b0;
                st_mpp  <= mode;
            end else begin
                mode    <= csr_isa_pkg::PRIV_S;
                scause  <= trap_i.cause;
                sepc    <= trap_i.pc;
                stval   <= '0;
                st_spie <= st_sie;
                st_sie  <= 1'b0;
                st_spp  <= mode[0];
            end
        end else if (trap_i.is_mret) begin
            mode    <= st_mpp;
            st_mie  <= st_mpie;
            st_mpie <= 1'b1;
            st_mpp  <= csr_isa_pkg::PRIV_U;
        end else if (trap_i.is_sret) begin
            mode    <= csr_isa_pkg::priv_mode_e'({1'b0, st_spp});
            st_sie  <= st_spie;
            st_spie <= 1'b1;
            st_spp  <= 1'b0;
        end else if (do_write) begin
            case (req_i.addr)
                csr_isa_pkg::ADDR_MSTATUS: begin
                    st_tsr  <= wdata[csr_isa_pkg::MSTATUS_TSR_BIT];
                    st_mpp  <= (wr_mpp == 2'b10) ? csr_isa_pkg::PRIV_U
                                                 : csr_isa_pkg::priv_mode_e'(wr_mpp);
                    st_spp  <= wdata[csr_isa_pkg::MSTATUS_SPP_BIT];
                    st_mpie <= wdata[csr_isa_pkg::MSTATUS_MPIE_BIT];
                    st_spie <= wdata[csr_isa_pkg::MSTATUS_SPIE_BIT];
                    st_mie  <= wdata[csr_isa_pkg::MSTATUS_MIE_BIT];
                    st_sie  <= wdata[csr_isa_pkg::MSTATUS_SIE_BIT];
                end
                // Only the S fields reach mstatus here
                csr_isa_pkg::ADDR_SSTATUS: begin
                    st_spp  <= wdata[csr_isa_pkg::MSTATUS_SPP_BIT];
                    st_spie <= wdata[csr_isa_pkg::MSTATUS_SPIE_BIT];
                    st_sie  <= wdata[csr_isa_pkg::MSTATUS_SIE_BIT];
                end
                csr_isa_pkg::ADDR_MEDELEG:  medeleg  <= wdata;
                csr_isa_pkg::ADDR_MTVEC:    mtvec    <= wdata;
                csr_isa_pkg::ADDR_MSCRATCH: mscratch <= wdata;
                csr_isa_pkg::ADDR_MEPC:     mepc     <= wdata;
                csr_isa_pkg::ADDR_MCAUSE:   mcause   <= wdata;
                csr_isa_pkg::ADDR_MTVAL:    mtval    <= wdata;
                csr_isa_pkg::ADDR_STVEC:    stvec    <= wdata;
                csr_isa_pkg::ADDR_SSCRATCH: sscratch <= wdata;
                csr_isa_pkg::ADDR_SEPC:     sepc     <= wdata;
                csr_isa_pkg::ADDR_SCAUSE:   scause   <= wdata;
                csr_isa_pkg::ADDR_STVAL:    stval    <= wdata;
                default: begin
                end
            endcase
        end
    end

    assign mode_o    = mode;
    assign tsr_o     = st_tsr;
    assign medeleg_o = medeleg;
    assign mtvec_o   = mtvec & csr_isa_pkg::XTVEC_BASE_MASK;
    assign stvec_o   = stvec & csr_isa_pkg::XTVEC_BASE_MASK;
    assign mepc_o    = mepc;
    assign sepc_o    = sepc;

endmodule

`default_nettype wire

// ==== verilog/csr_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit_top (
    input  wire                       clk,
    input  wire                       arst_n_i,
    input  wire                       req_valid_i,
    input  wire csr_if_pkg::csr_req_t req_i,
    output logic                      resp_valid_o,
    output csr_if_pkg::csr_resp_t     resp_o
);

    csr_isa_pkg::priv_mode_e mode;
    logic                    tsr;
    logic                    illegal;
    logic                    readonly;
    csr_isa_pkg::xlen_t      medeleg;
    csr_isa_pkg::xlen_t      mtvec;
    csr_isa_pkg::xlen_t      stvec;
    csr_isa_pkg::xlen_t      mepc;
    csr_isa_pkg::xlen_t      sepc;
    csr_isa_pkg::xlen_t      rdata;
    csr_if_pkg::trap_req_t   trap;

    csr_access_check i_access_check (
        .req_i      (req_i),
        .mode_i     (mode),
        .tsr_i      (tsr),
        .illegal_o  (illegal),
        .readonly_o (readonly)
    );

    csr_trap_ctrl i_trap_ctrl (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .illegal_i    (illegal),
        .mode_i       (mode),
        .medeleg_i    (medeleg),
        .mtvec_i      (mtvec),
        .stvec_i      (stvec),
        .mepc_i       (mepc),
        .sepc_i       (sepc),
        .rdata_i      (rdata),
        .trap_o       (trap),
        .resp_valid_o (resp_valid_o),
        .resp_o       (resp_o)
    );

    csr_regfile i_regfile (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .readonly_i  (readonly),
        .trap_i      (trap),
        .mode_o      (mode),
        .tsr_o       (tsr),
        .medeleg_o   (medeleg),
        .mtvec_o     (mtvec),
        .stvec_o     (stvec),
        .mepc_o      (mepc),
        .sepc_o      (sepc),
        .rdata_o     (rdata)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit;

    logic                  clk;
    logic                  arst_n_i;
    logic                  req_valid_i;
    csr_if_pkg::csr_req_t  req_i;
    logic                  resp_valid_o;
    csr_if_pkg::csr_resp_t resp_o;

    // Test vectors as read from the data file
    string                 names[$];
    csr_if_pkg::csr_req_t  reqs[$];
    csr_if_pkg::csr_resp_t exps[$];

    int cycles;
    int cycle_limit;
    int test_errs;
    int other_errs;
    int pass_count;
    int fail_count;

    csr_unit_top i_dut (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .resp_valid_o (resp_valid_o),
        .resp_o       (resp_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run went past %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check_word(input string name, input string field,
                              input csr_isa_pkg::xlen_t exp, input csr_isa_pkg::xlen_t act);
        if (act !== exp) begin
            $display("Error: %s %s expected %08h actual %08h", name, field, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_flag(input string name, input string field,
                              input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: %s %s expected %b actual %b", name, field, exp, act);
            test_errs++;
        end
    endtask

    // Data file columns are name cmd addr operand pc exc_valid exc_cause rdata no_wb redirect target
    task automatic load_tests();
        int                    fd;
        int                    n;
        string                 line;
        string                 name;
        logic [31:0]           cmd_v;
        logic [31:0]           addr_v;
        logic [31:0]           op_v;
        logic [31:0]           pc_v;
        logic [31:0]           excv_v;
        logic [31:0]           excc_v;
        logic [31:0]           rd_v;
        logic [31:0]           nowb_v;
        logic [31:0]           red_v;
        logic [31:0]           tgt_v;
        csr_if_pkg::csr_req_t  r;
        csr_if_pkg::csr_resp_t e;
        fd = $fopen("testbench/csr_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/csr_testdata.txt");
            other_errs++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                // Skip comments and blank lines
                if (line.len() > 1 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", name, cmd_v,
                                addr_v, op_v, pc_v, excv_v, excc_v, rd_v, nowb_v, red_v, tgt_v);
                    if (n == 11) begin
                        r           = '0;
                        r.cmd       = csr_isa_pkg::csr_cmd_e'(cmd_v[2:0]);
                        r.addr      = addr_v[11:0];
                        r.operand   = op_v;
                        r.pc        = pc_v;
                        r.exc_valid = excv_v[0];
                        r.exc_cause = excc_v;
                        e.rdata     = rd_v;
                        e.no_wb     = nowb_v[0];
                        e.redirect  = red_v[0];
                        e.target    = tgt_v;
                        names.push_back(name);
                        reqs.push_back(r);
                        exps.push_back(e);
                    end else begin
                        $display("Malformed line in test data: %s", line);
                        other_errs++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // One request with its response checked in the cycle after it is taken
    task automatic run_test(input int idx);
        string                 name;
        csr_if_pkg::csr_resp_t e;
        name      = names[idx];
        e         = exps[idx];
        test_errs = 0;
        @(posedge clk);
        req_valid_i <= 1'b1;
        req_i       <= reqs[idx];
        @(posedge clk);
        req_valid_i <= 1'b0;
        req_i       <= '0;
        @(negedge clk);
        if (resp_valid_o !== 1'b1) begin
            $display("Test %s: no valid response one cycle after the request", name);
            test_errs++;
        end else begin
            check_word(name, "rdata", e.rdata, resp_o.rdata);
            check_flag(name, "no_wb", e.no_wb, resp_o.no_wb);
            check_flag(name, "redirect", e.redirect, resp_o.redirect);
            check_word(name, "target", e.target, resp_o.target);
        end
        if (test_errs == 0) begin
            pass_count++;
            $display("PASS %s", name);
        end else begin
            fail_count++;
            $display("FAIL %s", name);
        end
    endtask

    initial begin
        clk         = 1'b0;
        arst_n_i    = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        cycles      = 0;
        cycle_limit = 50;
        other_errs  = 0;
        pass_count  = 0;
        fail_count  = 0;

        load_tests();
        cycle_limit = 4 * names.size() + 50;

        repeat (5) @(posedge clk);
        arst_n_i <= 1'b1;
        @(negedge clk);
        if (resp_valid_o !== 1'b0) begin
            $display("Response valid is not low after reset");
            other_errs++;
        end

        for (int i = 0; i < names.size(); i++) begin
            run_test(i);
        end

        $display("Tests run: %0d, passed: %0d, failed: %0d, other errors: %0d",
                 names.size(), pass_count, fail_count, other_errs);
        if (fail_count == 0 && other_errs == 0 && names.size() > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/csr_testdata.txt ====
# name cmd addr operand pc exc_valid exc_cause | expected: rdata no_wb redirect target
# cmd: 0 none, 1 write, 2 set, 3 clear, 4 ecall, 5 mret, 6 sret (all numbers in hex)
mscratch_write   1 340 12345678 00000000 0 00000000 00000000 0 0 00000000
mscratch_set     2 340 0000f000 00000000 0 00000000 12345678 0 0 00000000
mscratch_clear   3 340 00000678 00000000 0 00000000 1234f678 0 0 00000000
mscratch_read    0 340 00000000 00000000 0 00000000 1234f000 0 0 00000000
misa_read        0 301 00000000 00000000 0 00000000 40141101 0 0 00000000
readonly_write   1 c00 ffffffff 00000000 0 00000000 00000000 0 0 00000000
readonly_read    0 c00 00000000 00000000 0 00000000 00000000 0 0 00000000
mtvec_write      1 305 80000103 00000000 0 00000000 00000000 0 0 00000000
upstream_exc     0 000 00000000 00001000 1 00000005 00000000 1 1 80000100
mepc_read        0 341 00000000 00000000 0 00000000 00001000 0 0 00000000
mcause_read      0 342 00000000 00000000 0 00000000 00000005 0 0 00000000
ecall_m          4 000 00000000 00002000 0 00000000 00000000 1 1 80000100
mcause_ecall_m   0 342 00000000 00000000 0 00000000 0000000b 0 0 00000000
mepc_write       1 341 00003000 00000000 0 00000000 00002000 0 0 00000000
mstatus_mpp_s    1 300 00000800 00000000 0 00000000 00001800 0 0 00000000
mret_to_s        5 000 00000000 00000000 0 00000000 00000000 1 1 00003000
s_write_mscratch 1 340 00000000 00003004 0 00000000 00000000 1 1 80000100
mcause_illegal   0 342 00000000 00000000 0 00000000 00000002 0 0 00000000
mscratch_kept    0 340 00000000 00000000 0 00000000 1234f000 0 0 00000000
medeleg_write    1 302 00000200 00000000 0 00000000 00000000 0 0 00000000
stvec_write      1 105 40000002 00000000 0 00000000 00000000 0 0 00000000
mret_to_s_2      5 000 00000000 00000000 0 00000000 00000000 1 1 00003004
ecall_s          4 000 00000000 00005000 0 00000000 00000000 1 1 40000000
scause_read      0 142 00000000 00000000 0 00000000 00000009 0 0 00000000
sepc_read        0 141 00000000 00000000 0 00000000 00005000 0 0 00000000
sret_to_s        6 000 00000000 00000000 0 00000000 00000000 1 1 00005000
sstatus_read     0 100 00000000 00000000 0 00000000 00000020 0 0 00000000
exc_s_to_m       0 000 00000000 00006000 1 00000003 00000000 1 1 80000100
tsr_set          2 300 00400000 00000000 0 00000000 00000820 0 0 00000000
mret_to_s_3      5 000 00000000 00000000 0 00000000 00000000 1 1 00006000
sret_tsr         6 000 00000000 00007000 0 00000000 00000000 1 1 80000100
mcause_tsr       0 342 00000000 00000000 0 00000000 00000002 0 0 00000000
mret_to_s_4      5 000 00000000 00000000 0 00000000 00000000 1 1 00007000
mret_in_s        5 000 00000000 00008000 0 00000000 00000000 1 1 80000100
mepc_mret_s      0 341 00000000 00000000 0 00000000 00008000 0 0 00000000

// ==== src.f ====
verilog/csr_isa_pkg.sv
verilog/csr_if_pkg.sv
verilog/csr_access_check.sv
verilog/csr_trap_ctrl.sv
verilog/csr_regfile.sv
verilog/csr_unit_top.sv
testbench/tb_csr_unit.sv

// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - verilog/csr_isa_pkg.sv
  - verilog/csr_if_pkg.sv
  - verilog/csr_access_check.sv
  - verilog/csr_trap_ctrl.sv
  - verilog/csr_regfile.sv
  - verilog/csr_unit_top.sv
  - target: test
    files:
      - testbench/tb_csr_unit.sv
